//--- Makefile
# Verilator build and run of the receive path testbench

SRC := all.f $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_eth_rx
	./obj_dir/Vtb_eth_rx | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

obj_dir/Vtb_eth_rx: $(SRC)
	verilator --binary --timing --assert --top-module tb_eth_rx -f all.f

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+design
design/eth_rx_pkg.sv
design/axis_skid_buffer.sv
design/eth_axis_rx.sv
design/eth_mac_filter.sv
design/eth_rx_regs.sv
design/eth_rx_top.sv
sim/tb_eth_rx_assert.sv
sim/tb_eth_rx.sv

//--- design/axis_skid_buffer.sv
// two-entry register stage, one cycle latency at full rate; in_ready lags out_ready by a cycle
`timescale 1ns/10ps
`default_nettype none

module axis_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  wire      clk,
    input  wire      rst,
    input  payload_t in_data,
    input  wire      in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  wire      out_ready
);

    payload_t main_data;
    payload_t temp_data;
    logic     main_valid;
    logic     temp_valid;
    logic     ready_early;

    // space next cycle if the output drains, or the temp slot cannot fill this cycle
    assign ready_early = out_ready | (~temp_valid & (~main_valid | ~in_valid));

    assign out_data  = main_data;
    assign out_valid = main_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready   <= 1'b0;
            main_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (in_ready) begin
                if (out_ready | ~main_valid) begin
                    main_valid <= in_valid;
                end else begin
                    temp_valid <= in_valid;
                end
            end else if (out_ready) begin
                // refill the output from the temp slot
                main_valid <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            if (out_ready | ~main_valid) begin
                main_data <= in_data;
            end else begin
                temp_data <= in_data;
            end
        end else if (out_ready) begin
            main_data <= temp_data;
        end
    end

endmodule

`default_nettype wire

//--- design/eth_axis_rx.sv
// strips the 14-byte header; a new frame waits until the previous header is taken and payload drained
`timescale 1ns/10ps
`default_nettype none

module eth_axis_rx (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [7:0]             rx_data,
    input  wire                   rx_valid,
    input  wire                   rx_last,
    input  wire                   rx_user,
    output logic                  rx_ready,
    output logic                  hdr_valid,
    input  wire                   hdr_ready,
    output eth_rx_pkg::mac_addr_t dest_mac,
    output eth_rx_pkg::mac_addr_t src_mac,
    output eth_rx_pkg::eth_type_t eth_type,
    output logic [7:0]            pl_data,
    output logic                  pl_valid,
    output logic                  pl_last,
    output logic                  pl_user,
    input  wire                   pl_ready,
    output logic                  early_term
);

    import eth_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    localparam int HDR_BYTES = 14;

    state_t     state;
    state_t     state_next;
    logic [3:0] byte_cnt;
    logic [3:0] byte_cnt_next;
    logic       ready_q;
    logic       ready_next;
    logic       hdr_valid_next;
    logic       early_next;
    logic       store_byte;
    logic       rx_fire;
    eth_hdr_t   hdr_q;
    axis_beat_t beat_in;
    axis_beat_t beat_out;
    logic       beat_in_valid;
    logic       beat_in_ready;

    // payload ready comes straight from the registered ready of the skid stage
    assign rx_ready = (state == ST_PAYLOAD) ? beat_in_ready : ready_q;
    assign rx_fire  = rx_valid & rx_ready;

    always_comb begin
        state_next     = state;
        byte_cnt_next  = byte_cnt;
        hdr_valid_next = hdr_valid & ~hdr_ready;
        early_next     = 1'b0;
        store_byte     = 1'b0;
        case (state)
            ST_IDLE, ST_HEADER: begin
                if (rx_fire) begin
                    store_byte    = 1'b1;
                    byte_cnt_next = byte_cnt + 4'd1;
                    state_next    = ST_HEADER;
                    if (byte_cnt == 4'(HDR_BYTES - 1)) begin
                        // header complete, a 14-byte frame has no payload
                        hdr_valid_next = 1'b1;
                        state_next     = rx_last ? ST_IDLE : ST_PAYLOAD;
                    end else if (rx_last) begin
                        early_next = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_PAYLOAD: begin
                if (rx_fire && rx_last) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase

        if (state_next == ST_IDLE) begin
            byte_cnt_next = 4'd0;
        end

        // keep frames apart so the filter never sees a header ahead of older payload
        ready_next = (state_next == ST_HEADER) |
                     (~hdr_valid_next & ~pl_valid & ~(beat_in_valid & beat_in_ready));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            byte_cnt   <= 4'd0;
            ready_q    <= 1'b0;
            hdr_valid  <= 1'b0;
            early_term <= 1'b0;
        end else begin
            state      <= state_next;
            byte_cnt   <= byte_cnt_next;
            ready_q    <= ready_next;
            hdr_valid  <= hdr_valid_next;
            early_term <= early_next;
        end
    end

    // byte n of the frame goes to byte lane 13-n, first byte most significant
    always_ff @(posedge clk) begin
        if (store_byte) begin
            hdr_q[(HDR_BYTES - 1 - byte_cnt) * 8 +: 8] <= rx_data;
        end
    end

    assign dest_mac = hdr_q.dest;
    assign src_mac  = hdr_q.src;
    assign eth_type = hdr_q.etype;

    assign beat_in       = '{data: rx_data, last: rx_last, user: rx_user};
    assign beat_in_valid = rx_valid & (state == ST_PAYLOAD);

    axis_skid_buffer #(
        .payload_t(axis_beat_t)
    ) u_pl_skid (
        .clk      (clk),
        .rst      (rst),
        .in_data  (beat_in),
        .in_valid (beat_in_valid),
        .in_ready (beat_in_ready),
        .out_data (beat_out),
        .out_valid(pl_valid),
        .out_ready(pl_ready)
    );

    assign pl_data = beat_out.data;
    assign pl_last = beat_out.last;
    assign pl_user = beat_out.user;

endmodule

`default_nettype wire

//--- design/eth_mac_filter.sv
// whole-frame pass or drop by destination; relies on the parser never overlapping frames
`timescale 1ns/10ps
`default_nettype none

module eth_mac_filter (
    input  wire                   clk,
    input  wire                   rst,
    input  eth_rx_pkg::mac_addr_t station_mac,
    input  wire                   promisc,
    input  wire                   in_hdr_valid,
    output logic                  in_hdr_ready,
    input  eth_rx_pkg::mac_addr_t in_dest_mac,
    input  eth_rx_pkg::mac_addr_t in_src_mac,
    input  eth_rx_pkg::eth_type_t in_eth_type,
    input  wire [7:0]             in_pl_data,
    input  wire                   in_pl_valid,
    input  wire                   in_pl_last,
    input  wire                   in_pl_user,
    output logic                  in_pl_ready,
    output logic                  hdr_valid,
    input  wire                   hdr_ready,
    output eth_rx_pkg::mac_addr_t dest_mac,
    output eth_rx_pkg::mac_addr_t src_mac,
    output eth_rx_pkg::eth_type_t eth_type,
    output logic [7:0]            out_data,
    output logic                  out_valid,
    output logic                  out_last,
    output logic                  out_user,
    input  wire                   out_ready,
    output logic                  frame_accepted,
    output logic                  frame_dropped
);

    import eth_rx_pkg::*;

    eth_hdr_t   hdr_in;
    eth_hdr_t   hdr_out;
    axis_beat_t beat_in;
    axis_beat_t beat_out;
    logic       accept;
    logic       hdr_fire;
    logic       hdr_skid_ready;
    logic       pl_open;
    logic       pl_fire;
    logic       pl_skid_ready;
    logic       dec_valid;
    logic       dec_pass;

    // own address, broadcast, or anything in promiscuous mode
    assign accept = promisc | (in_dest_mac == station_mac) | (&in_dest_mac);

    // a dropped header needs no room in the header stage
    assign in_hdr_ready = hdr_skid_ready | ~accept;
    assign hdr_fire     = in_hdr_valid & in_hdr_ready;

    // payload waits until its own header has been decided
    assign pl_open     = dec_valid & ~in_hdr_valid;
    assign in_pl_ready = pl_open & (~dec_pass | pl_skid_ready);
    assign pl_fire     = in_pl_valid & in_pl_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid      <= 1'b0;
            dec_pass       <= 1'b0;
            frame_accepted <= 1'b0;
            frame_dropped  <= 1'b0;
        end else begin
            frame_accepted <= hdr_fire & accept;
            frame_dropped  <= hdr_fire & ~accept;
            if (hdr_fire) begin
                dec_valid <= 1'b1;
                dec_pass  <= accept;
            end else if (pl_fire && in_pl_last) begin
                dec_valid <= 1'b0;
            end
        end
    end

    assign hdr_in = '{dest: in_dest_mac, src: in_src_mac, etype: in_eth_type};

    axis_skid_buffer #(
        .payload_t(eth_hdr_t)
    ) u_hdr_skid (
        .clk      (clk),
        .rst      (rst),
        .in_data  (hdr_in),
        .in_valid (in_hdr_valid & accept),
        .in_ready (hdr_skid_ready),
        .out_data (hdr_out),
        .out_valid(hdr_valid),
        .out_ready(hdr_ready)
    );

    assign dest_mac = hdr_out.dest;
    assign src_mac  = hdr_out.src;
    assign eth_type = hdr_out.etype;

    assign beat_in = '{data: in_pl_data, last: in_pl_last, user: in_pl_user};

    // dropped payload is sunk here and never reaches the stage
    axis_skid_buffer #(
        .payload_t(axis_beat_t)
    ) u_pl_skid (
        .clk      (clk),
        .rst      (rst),
        .in_data  (beat_in),
        .in_valid (in_pl_valid & pl_open & dec_pass),
        .in_ready (pl_skid_ready),
        .out_data (beat_out),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    assign out_data = beat_out.data;
    assign out_last = beat_out.last;
    assign out_user = beat_out.user;

endmodule

`default_nettype wire

//--- design/eth_rx_defines.svh
// register map and widths of the receive path; the register layout assumes 32-bit APB data
`ifndef ETH_RX_DEFINES_SVH
`define ETH_RX_DEFINES_SVH

// APB bus widths
`define ETH_RX_APB_DW 32
`define ETH_RX_APB_AW 8

// frame counters wrap at this width
`define ETH_RX_CNT_W 16

// byte offsets of the registers
`define ETH_RX_REG_CTRL      8'h00
`define ETH_RX_REG_MAC_LO    8'h04
`define ETH_RX_REG_MAC_HI    8'h08
`define ETH_RX_REG_CNT_OK    8'h0C
`define ETH_RX_REG_CNT_DROP  8'h10
`define ETH_RX_REG_CNT_EARLY 8'h14

`endif

//--- design/eth_rx_pkg.sv
// shared stream and header types; multi-byte fields hold the first byte on the wire in the MSBs
`default_nettype none

package eth_rx_pkg;

    // 48-bit MAC address, first transmitted byte in bits 47:40
    typedef logic [47:0] mac_addr_t;

    // ethertype, high byte first
    typedef logic [15:0] eth_type_t;

    // one byte of a frame with its flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    // full 14-byte header in wire order
    typedef struct packed {
        mac_addr_t dest;
        mac_addr_t src;
        eth_type_t etype;
    } eth_hdr_t;

endpackage

`default_nettype wire

//--- design/eth_rx_regs.sv
// APB slave without wait states or errors; unmapped reads give zero, counters are read-only
`timescale 1ns/10ps
`default_nettype none
`include "eth_rx_defines.svh"

module eth_rx_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [`ETH_RX_APB_AW-1:0]   paddr,
    input  wire [`ETH_RX_APB_DW-1:0]   pwdata,
    output logic [`ETH_RX_APB_DW-1:0]  prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire                        frame_accepted,
    input  wire                        frame_dropped,
    input  wire                        early_term,
    output eth_rx_pkg::mac_addr_t      station_mac,
    output logic                       promisc
);

    logic [31:0]              mac_lo;
    logic [15:0]              mac_hi;
    logic [`ETH_RX_CNT_W-1:0] cnt_ok;
    logic [`ETH_RX_CNT_W-1:0] cnt_drop;
    logic [`ETH_RX_CNT_W-1:0] cnt_early;
    logic                     wr_en;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;
    assign wr_en   = psel & penable & pwrite;

    assign station_mac = {mac_hi, mac_lo};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            promisc <= 1'b0;
            mac_lo  <= 32'd0;
            mac_hi  <= 16'd0;
        end else if (wr_en) begin
            case (paddr)
                `ETH_RX_REG_CTRL:   promisc <= pwdata[0];
                `ETH_RX_REG_MAC_LO: mac_lo  <= pwdata[31:0];
                `ETH_RX_REG_MAC_HI: mac_hi  <= pwdata[15:0];
                default: ;
            endcase
        end
    end

    // frame counters, free running and wrapping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_ok    <= '0;
            cnt_drop  <= '0;
            cnt_early <= '0;
        end else begin
            if (frame_accepted) begin
                cnt_ok <= cnt_ok + 1'b1;
            end
            if (frame_dropped) begin
                cnt_drop <= cnt_drop + 1'b1;
            end
            if (early_term) begin
                cnt_early <= cnt_early + 1'b1;
            end
        end
    end

    // read data is valid through the access phase
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                `ETH_RX_REG_CTRL:      prdata[0] = promisc;
                `ETH_RX_REG_MAC_LO:    prdata[31:0] = mac_lo;
                `ETH_RX_REG_MAC_HI:    prdata[15:0] = mac_hi;
                `ETH_RX_REG_CNT_OK:    prdata[`ETH_RX_CNT_W-1:0] = cnt_ok;
                `ETH_RX_REG_CNT_DROP:  prdata[`ETH_RX_CNT_W-1:0] = cnt_drop;
                `ETH_RX_REG_CNT_EARLY: prdata[`ETH_RX_CNT_W-1:0] = cnt_early;
                default:               prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/eth_rx_top.sv
// receive path top; hdr and out streams are separate, the n-th header belongs to the n-th frame
`timescale 1ns/10ps
`default_nettype none
`include "eth_rx_defines.svh"

module eth_rx_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [7:0]                  rx_data,
    input  wire                        rx_valid,
    input  wire                        rx_last,
    input  wire                        rx_user,
    output logic                       rx_ready,
    output logic                       hdr_valid,
    input  wire                        hdr_ready,
    output eth_rx_pkg::mac_addr_t      dest_mac,
    output eth_rx_pkg::mac_addr_t      src_mac,
    output eth_rx_pkg::eth_type_t      eth_type,
    output logic [7:0]                 out_data,
    output logic                       out_valid,
    output logic                       out_last,
    output logic                       out_user,
    input  wire                        out_ready,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [`ETH_RX_APB_AW-1:0]   paddr,
    input  wire [`ETH_RX_APB_DW-1:0]   pwdata,
    output logic [`ETH_RX_APB_DW-1:0]  prdata,
    output logic                       pready,
    output logic                       pslverr
);

    import eth_rx_pkg::*;

    // parser to filter
    logic       p_hdr_valid;
    logic       p_hdr_ready;
    mac_addr_t  p_dest_mac;
    mac_addr_t  p_src_mac;
    eth_type_t  p_eth_type;
    logic [7:0] p_pl_data;
    logic       p_pl_valid;
    logic       p_pl_last;
    logic       p_pl_user;
    logic       p_pl_ready;

    // control and status
    mac_addr_t  station_mac;
    logic       promisc;
    logic       frame_accepted;
    logic       frame_dropped;
    logic       early_term;

    eth_axis_rx u_parser (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_last   (rx_last),
        .rx_user   (rx_user),
        .rx_ready  (rx_ready),
        .hdr_valid (p_hdr_valid),
        .hdr_ready (p_hdr_ready),
        .dest_mac  (p_dest_mac),
        .src_mac   (p_src_mac),
        .eth_type  (p_eth_type),
        .pl_data   (p_pl_data),
        .pl_valid  (p_pl_valid),
        .pl_last   (p_pl_last),
        .pl_user   (p_pl_user),
        .pl_ready  (p_pl_ready),
        .early_term(early_term)
    );

    eth_mac_filter u_filter (
        .clk           (clk),
        .rst           (rst),
        .station_mac   (station_mac),
        .promisc       (promisc),
        .in_hdr_valid  (p_hdr_valid),
        .in_hdr_ready  (p_hdr_ready),
        .in_dest_mac   (p_dest_mac),
        .in_src_mac    (p_src_mac),
        .in_eth_type   (p_eth_type),
        .in_pl_data    (p_pl_data),
        .in_pl_valid   (p_pl_valid),
        .in_pl_last    (p_pl_last),
        .in_pl_user    (p_pl_user),
        .in_pl_ready   (p_pl_ready),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .dest_mac      (dest_mac),
        .src_mac       (src_mac),
        .eth_type      (eth_type),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_user      (out_user),
        .out_ready     (out_ready),
        .frame_accepted(frame_accepted),
        .frame_dropped (frame_dropped)
    );

    eth_rx_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .frame_accepted(frame_accepted),
        .frame_dropped (frame_dropped),
        .early_term    (early_term),
        .station_mac   (station_mac),
        .promisc       (promisc)
    );

endmodule

`default_nettype wire

//--- sim/tb_eth_rx.sv
// random frames against a queue model; promisc goes on halfway, each APB access runs while idle
`timescale 1ns/10ps
`default_nettype none
`include "eth_rx_defines.svh"

module tb_eth_rx;

    localparam int NUM_FRAMES       = 200;
    localparam int CYCLES_PER_FRAME = 60;
    localparam int CLK_PERIOD       = 10;
    // frame budget plus room for reset and the register accesses
    localparam int TIMEOUT_CYCLES   = NUM_FRAMES * CYCLES_PER_FRAME + 1000;

    logic                       clk;
    logic                       rst;
    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       rx_last;
    logic                       rx_user;
    logic                       rx_ready;
    logic                       hdr_valid;
    logic                       hdr_ready;
    logic [47:0]                dest_mac;
    logic [47:0]                src_mac;
    logic [15:0]                eth_type;
    logic [7:0]                 out_data;
    logic                       out_valid;
    logic                       out_last;
    logic                       out_user;
    logic                       out_ready;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`ETH_RX_APB_AW-1:0]  paddr;
    logic [`ETH_RX_APB_DW-1:0]  pwdata;
    logic [`ETH_RX_APB_DW-1:0]  prdata;
    logic                       pready;
    logic                       pslverr;

    // reference model: expected outputs of passed frames, in order
    logic [111:0] exp_hdr_q[$];
    logic [9:0]   exp_beat_q[$];
    logic [47:0]  station_mac;
    logic         promisc_on;
    int           exp_ok;
    int           exp_drop;
    int           exp_early;
    int           error_count;
    int           check_count;

    eth_rx_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [111:0] expected,
                               input logic [111:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    task automatic write_register(input logic [`ETH_RX_APB_AW-1:0] addr,
                                  input logic [`ETH_RX_APB_DW-1:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic expect_register(input string name, input logic [`ETH_RX_APB_AW-1:0] addr,
                                   input logic [`ETH_RX_APB_DW-1:0] expected);
        logic [`ETH_RX_APB_DW-1:0] value;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        value = prdata;
        check_value("pslverr", 112'(1'b0), 112'(pslverr));
        check_value(name, 112'(expected), 112'(value));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // builds one frame, predicts its outcome, then drives it byte by byte
    task automatic send_frame();
        logic [7:0]  frame_bytes[$];
        logic [47:0] dest;
        logic [47:0] src;
        logic [15:0] etype;
        logic        last_user;
        logic        is_last;
        int          kind;
        int          len;
        last_user = ($urandom_range(1, 0) != 0);
        if ($urandom_range(9, 0) == 0) begin
            // runt, ends inside the header
            len = int'($urandom_range(13, 1));
            for (int i = 0; i < len; i++) begin
                frame_bytes.push_back(8'($urandom));
            end
            exp_early++;
        end else begin
            kind = int'($urandom_range(2, 0));
            case (kind)
                0:       dest = station_mac;
                1:       dest = '1;
                default: dest = {16'($urandom), $urandom};
            endcase
            src   = {16'($urandom), $urandom};
            etype = 16'($urandom);
            len   = int'($urandom_range(40, 0));
            for (int i = 5; i >= 0; i--) begin
                frame_bytes.push_back(dest[i*8 +: 8]);
            end
            for (int i = 5; i >= 0; i--) begin
                frame_bytes.push_back(src[i*8 +: 8]);
            end
            frame_bytes.push_back(etype[15:8]);
            frame_bytes.push_back(etype[7:0]);
            for (int i = 0; i < len; i++) begin
                frame_bytes.push_back(8'($urandom));
            end
            if (promisc_on || (dest == station_mac) || (&dest)) begin
                exp_ok++;
                exp_hdr_q.push_back({dest, src, etype});
                for (int i = 14; i < frame_bytes.size(); i++) begin
                    is_last = (i == frame_bytes.size() - 1);
                    exp_beat_q.push_back({frame_bytes[i], is_last, is_last & last_user});
                end
            end else begin
                exp_drop++;
            end
        end

        foreach (frame_bytes[i]) begin
            if ($urandom_range(7, 0) == 0) begin
                rx_valid = 1'b0;
                repeat ($urandom_range(2, 1)) @(negedge clk);
            end
            rx_data  = frame_bytes[i];
            rx_last  = (i == frame_bytes.size() - 1);
            rx_user  = rx_last & last_user;
            rx_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!rx_ready);
            @(negedge clk);
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        rx_user  = 1'b0;
    endtask

    // all expected output seen and the parser ready for a new frame
    task automatic wait_until_idle();
        do begin
            @(posedge clk);
        end while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 || !rx_ready ||
                   hdr_valid || out_valid);
        @(negedge clk);
    endtask

    always @(posedge clk) begin : output_monitor
        logic [111:0] exp_hdr;
        logic [9:0]   exp_beat;
        if (!rst) begin
            if (hdr_valid && hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    note_failure("a header came out that no passed frame accounts for");
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check_value("dest_mac", 112'(exp_hdr[111:64]), 112'(dest_mac));
                    check_value("src_mac", 112'(exp_hdr[63:16]), 112'(src_mac));
                    check_value("eth_type", 112'(exp_hdr[15:0]), 112'(eth_type));
                end
            end
            if (out_valid && out_ready) begin
                if (exp_beat_q.size() == 0) begin
                    note_failure("a payload byte came out that no passed frame accounts for");
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    check_value("out_data", 112'(exp_beat[9:2]), 112'(out_data));
                    check_value("out_last", 112'(exp_beat[1]), 112'(out_last));
                    check_value("out_user", 112'(exp_beat[0]), 112'(out_user));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        rx_last     = 1'b0;
        rx_user     = 1'b0;
        hdr_ready   = 1'b0;
        out_ready   = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        promisc_on  = 1'b0;
        exp_ok      = 0;
        exp_drop    = 0;
        exp_early   = 0;
        error_count = 0;
        check_count = 0;
        void'($urandom(32'hf735));
        station_mac = {16'($urandom), $urandom};
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // random back-pressure on both output streams
        fork
            forever begin
                @(negedge clk);
                hdr_ready = ($urandom_range(3, 0) != 0);
                out_ready = ($urandom_range(3, 0) != 0);
            end
        join_none

        write_register(`ETH_RX_REG_MAC_LO, station_mac[31:0]);
        write_register(`ETH_RX_REG_MAC_HI, {16'h0000, station_mac[47:32]});
        write_register(`ETH_RX_REG_CTRL, 32'h0);
        expect_register("mac_lo", `ETH_RX_REG_MAC_LO, station_mac[31:0]);
        expect_register("mac_hi", `ETH_RX_REG_MAC_HI, {16'h0000, station_mac[47:32]});
        expect_register("ctrl", `ETH_RX_REG_CTRL, 32'h0);

        for (int n = 0; n < NUM_FRAMES; n++) begin
            if (n == NUM_FRAMES / 2) begin
                wait_until_idle();
                write_register(`ETH_RX_REG_CTRL, 32'h1);
                promisc_on = 1'b1;
                expect_register("ctrl", `ETH_RX_REG_CTRL, 32'h1);
            end
            send_frame();
        end
        wait_until_idle();

        expect_register("cnt_ok", `ETH_RX_REG_CNT_OK, 32'(exp_ok));
        expect_register("cnt_drop", `ETH_RX_REG_CNT_DROP, 32'(exp_drop));
        expect_register("cnt_early", `ETH_RX_REG_CNT_EARLY, 32'(exp_early));

        $display("frames: %0d passed, %0d dropped, %0d runts; checks: %0d, errors: %0d",
                 exp_ok, exp_drop, exp_early, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_eth_rx_assert.sv
// stream handshake and reset properties on the top-level ports, bound into every eth_rx_top
`timescale 1ns/10ps
`default_nettype none

module tb_eth_rx_assert (
    input wire        clk,
    input wire        rst,
    input wire [7:0]  rx_data,
    input wire        rx_valid,
    input wire        rx_last,
    input wire        rx_user,
    input wire        rx_ready,
    input wire        hdr_valid,
    input wire        hdr_ready,
    input wire [47:0] dest_mac,
    input wire [47:0] src_mac,
    input wire [15:0] eth_type,
    input wire [7:0]  out_data,
    input wire        out_valid,
    input wire        out_last,
    input wire        out_user,
    input wire        out_ready,
    input wire        pready
);

    // a stalled beat keeps valid and its payload until it transfers
    rx_hold: assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid && $stable({rx_data, rx_last, rx_user}))
        else $error("rx beat changed while stalled");

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable({dest_mac, src_mac, eth_type}))
        else $error("header changed while stalled");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_data, out_last, out_user}))
        else $error("payload beat changed while stalled");

    // nothing is offered or accepted straight out of reset
    reset_quiet: assert property (@(posedge clk)
        rst |=> !rx_ready && !hdr_valid && !out_valid)
        else $error("stream handshake active right after reset");

    no_wait_states: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready low");

endmodule

bind eth_rx_top tb_eth_rx_assert u_assert (.*);

`default_nettype wire
